// ==== bomber_pkg.sv ====
package bomber_pkg;

    // board geometry
    localparam int GRID_BITS = 4;
    localparam int GRID_MAX  = (1 << GRID_BITS) - 1;
    localparam int TILE_BITS = 2 * GRID_BITS;
    localparam int NUM_TILES = 1 << TILE_BITS;
    localparam int WALL_BITS = 2;

    // axis slots in the row/column view of a tile address
    localparam int AXIS_X = 0;
    localparam int AXIS_Y = 1;

    // direction command codes, 5..7 behave like stop
    localparam int DIR_BITS  = 3;
    localparam int FACE_BITS = 2;
    localparam logic [DIR_BITS-1:0] DIR_UP    = 3'd0;
    localparam logic [DIR_BITS-1:0] DIR_DOWN  = 3'd1;
    localparam logic [DIR_BITS-1:0] DIR_LEFT  = 3'd2;
    localparam logic [DIR_BITS-1:0] DIR_RIGHT = 3'd3;
    localparam logic [DIR_BITS-1:0] DIR_STOP  = 3'd4;

    // bomb rules
    localparam int BOMB_CNT_BITS = 3;
    localparam logic [BOMB_CNT_BITS-1:0] BOMB_MAX = 3'd5;

    // cycles after an execute during which bombs are refused
    localparam int BOMB_COOLDOWN = 3;
    localparam int COOLDOWN_BITS = $clog2(BOMB_COOLDOWN + 1);

    // player command FSM states
    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_EXEC = 1'b1;

    // reset tiles, top-left and bottom-right corners
    localparam logic [TILE_BITS-1:0] P1_START = 8'd0;
    localparam logic [TILE_BITS-1:0] P2_START = 8'd255;

    // one tile address word, seen either as the flat index y*16+x
    // or as a row/column pair with y in the upper nibble
    typedef union packed {
        logic [TILE_BITS-1:0]           flat;
        logic [1:0][GRID_BITS-1:0]      rc;
    } tile_addr_t;

endpackage

// ==== player_fsm.sv ====
`timescale 1ns/100ps

module player_fsm
    import bomber_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic i_cmd_valid,
    output logic o_exec
);

    logic state_q;
    logic state_d;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_cmd_valid) begin
                    state_d = ST_EXEC;
                end
            end
            ST_EXEC: begin
                // strobes arriving here are dropped
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // one execute cycle per accepted strobe
    assign o_exec = (state_q == ST_EXEC);

    // an execute cycle is always followed by a return to idle
    a_exec_single: assert property (
        @(posedge clk) disable iff (rst)
        o_exec |=> !o_exec
    ) else $error("player_fsm: o_exec high two cycles in a row");

endmodule

// ==== bomb_cooldown.sv ====
`timescale 1ns/100ps

module bomb_cooldown
    import bomber_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic i_exec,
    output logic o_bomb_ready
);

    logic [COOLDOWN_BITS-1:0] count_q;

    // reload at the end of every execute cycle, then count down to zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q <= '0;
        end else if (i_exec) begin
            count_q <= COOLDOWN_BITS'(BOMB_COOLDOWN);
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // ready only once the window has fully run out
    assign o_bomb_ready = (count_q == '0);

    // counter stays within the reload value
    a_count_range: assert property (
        @(posedge clk) disable iff (rst)
        count_q <= COOLDOWN_BITS'(BOMB_COOLDOWN)
    ) else $error("bomb_cooldown: count %0d above limit", count_q);

endmodule

// ==== tile_probe.sv ====
`timescale 1ns/100ps

module tile_probe
    import bomber_pkg::*;
(
    input  tile_addr_t                         i_pos,
    input  logic [DIR_BITS-1:0]                i_dir,
    input  logic [NUM_TILES*WALL_BITS-1:0]     i_wall_map,
    input  logic [NUM_TILES-1:0]               i_bomb_map,
    output logic                               o_blocked
);

    tile_addr_t           nbr;
    logic                 off_edge;
    logic                 no_move;
    logic [WALL_BITS-1:0] wall_code;
    logic                 bomb_hit;

    // neighbor tile in the requested direction
    always_comb begin
        nbr      = i_pos;
        off_edge = 1'b0;
        no_move  = 1'b0;
        case (i_dir)
            DIR_UP: begin
                if (i_pos.rc[AXIS_Y] == '0) begin
                    off_edge = 1'b1;
                end else begin
                    nbr.rc[AXIS_Y] = i_pos.rc[AXIS_Y] - 1'b1;
                end
            end
            DIR_DOWN: begin
                if (i_pos.rc[AXIS_Y] == GRID_BITS'(GRID_MAX)) begin
                    off_edge = 1'b1;
                end else begin
                    nbr.rc[AXIS_Y] = i_pos.rc[AXIS_Y] + 1'b1;
                end
            end
            DIR_LEFT: begin
                if (i_pos.rc[AXIS_X] == '0) begin
                    off_edge = 1'b1;
                end else begin
                    nbr.rc[AXIS_X] = i_pos.rc[AXIS_X] - 1'b1;
                end
            end
            DIR_RIGHT: begin
                if (i_pos.rc[AXIS_X] == GRID_BITS'(GRID_MAX)) begin
                    off_edge = 1'b1;
                end else begin
                    nbr.rc[AXIS_X] = i_pos.rc[AXIS_X] + 1'b1;
                end
            end
            default: begin
                // stop and unused codes
                no_move = 1'b1;
            end
        endcase
    end

    // map lookups on the flat index
    assign wall_code = i_wall_map[nbr.flat*WALL_BITS +: WALL_BITS];
    assign bomb_hit  = i_bomb_map[nbr.flat];

    // any wall code other than zero blocks
    assign o_blocked = no_move | off_edge | (wall_code != '0) | bomb_hit;

endmodule

// ==== player_unit.sv ====
`timescale 1ns/100ps

module player_unit
    import bomber_pkg::*;
#(
    parameter logic [TILE_BITS-1:0] START_TILE = P1_START
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_cmd_valid,
    input  logic [DIR_BITS-1:0]            i_dir,
    input  logic                           i_bomb,
    input  logic [BOMB_CNT_BITS-1:0]       i_bomb_num,
    input  logic [NUM_TILES*WALL_BITS-1:0] i_wall_map,
    input  logic [NUM_TILES-1:0]           i_bomb_map,
    output tile_addr_t                     o_pos,
    output logic [FACE_BITS-1:0]           o_face,
    output logic                           o_set_bomb
);

    logic                 exec;
    logic                 bomb_ready;
    logic                 blocked;
    logic                 accept;
    logic [DIR_BITS-1:0]  dir_q;
    logic                 bomb_q;
    tile_addr_t           pos_q;
    tile_addr_t           pos_step;
    logic [FACE_BITS-1:0] face_q;
    logic                 set_bomb_q;

    // true when two addresses are exactly one tile apart on one axis
    function automatic logic one_step(input tile_addr_t a, input tile_addr_t b);
        logic [GRID_BITS-1:0] dx;
        logic [GRID_BITS-1:0] dy;
        dx = b.rc[AXIS_X] - a.rc[AXIS_X];
        dy = b.rc[AXIS_Y] - a.rc[AXIS_Y];
        return ((dy == '0) && ((dx == 4'h1) || (dx == 4'hF))) ||
               ((dx == '0) && ((dy == 4'h1) || (dy == 4'hF)));
    endfunction

    player_fsm u_fsm (
        .clk         (clk),
        .rst         (rst),
        .i_cmd_valid (i_cmd_valid),
        .o_exec      (exec)
    );

    bomb_cooldown u_cooldown (
        .clk          (clk),
        .rst          (rst),
        .i_exec       (exec),
        .o_bomb_ready (bomb_ready)
    );

    tile_probe u_probe (
        .i_pos      (pos_q),
        .i_dir      (dir_q),
        .i_wall_map (i_wall_map),
        .i_bomb_map (i_bomb_map),
        .o_blocked  (blocked)
    );

    // fsm is idle whenever it is not executing
    assign accept = i_cmd_valid & ~exec;

    // command latch
    always_ff @(posedge clk) begin
        if (accept) begin
            dir_q  <= i_dir;
            bomb_q <= i_bomb;
        end
    end

    // stepped position, only taken when the probe says the tile is free
    always_comb begin
        pos_step = pos_q;
        case (dir_q)
            DIR_UP:    pos_step.rc[AXIS_Y] = pos_q.rc[AXIS_Y] - 1'b1;
            DIR_DOWN:  pos_step.rc[AXIS_Y] = pos_q.rc[AXIS_Y] + 1'b1;
            DIR_LEFT:  pos_step.rc[AXIS_X] = pos_q.rc[AXIS_X] - 1'b1;
            DIR_RIGHT: pos_step.rc[AXIS_X] = pos_q.rc[AXIS_X] + 1'b1;
            default:   pos_step = pos_q;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos_q.flat <= START_TILE;
            face_q     <= FACE_BITS'(DIR_UP);
            set_bomb_q <= 1'b0;
        end else begin
            // bomb count is sampled during the execute cycle
            set_bomb_q <= exec & bomb_q & bomb_ready & (i_bomb_num < BOMB_MAX);
            if (exec) begin
                if (!blocked) begin
                    pos_q <= pos_step;
                end
                if (dir_q < DIR_STOP) begin
                    face_q <= dir_q[FACE_BITS-1:0];
                end
            end
        end
    end

    assign o_pos      = pos_q;
    assign o_face     = face_q;
    assign o_set_bomb = set_bomb_q;

    // moves happen only after execute, one tile at a time
    a_move_step: assert property (
        @(posedge clk) disable iff (rst)
        !$stable(pos_q) |-> $past(exec) && one_step($past(pos_q), pos_q)
    ) else $error("player_unit: illegal move %h -> %h", $past(pos_q), pos_q);

endmodule

// ==== bomber_ctrl_top.sv ====
`timescale 1ns/100ps

module bomber_ctrl_top
    import bomber_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_cmd_valid_1,
    input  logic [DIR_BITS-1:0]            i_dir_1,
    input  logic                           i_bomb_1,
    input  logic [BOMB_CNT_BITS-1:0]       i_bomb_num_1,
    input  logic                           i_cmd_valid_2,
    input  logic [DIR_BITS-1:0]            i_dir_2,
    input  logic                           i_bomb_2,
    input  logic [BOMB_CNT_BITS-1:0]       i_bomb_num_2,
    input  logic [NUM_TILES*WALL_BITS-1:0] i_wall_map,
    input  logic [NUM_TILES-1:0]           i_bomb_map,
    output logic [GRID_BITS-1:0]           o_p1_x,
    output logic [GRID_BITS-1:0]           o_p1_y,
    output logic [TILE_BITS-1:0]           o_p1_coord,
    output logic [FACE_BITS-1:0]           o_p1_face,
    output logic                           o_p1_set_bomb,
    output logic [GRID_BITS-1:0]           o_p2_x,
    output logic [GRID_BITS-1:0]           o_p2_y,
    output logic [TILE_BITS-1:0]           o_p2_coord,
    output logic [FACE_BITS-1:0]           o_p2_face,
    output logic                           o_p2_set_bomb
);

    tile_addr_t p1_pos;
    tile_addr_t p2_pos;

    // both players see the same wall and bomb maps
    player_unit #(.START_TILE(P1_START)) u_p1 (
        .clk         (clk),
        .rst         (rst),
        .i_cmd_valid (i_cmd_valid_1),
        .i_dir       (i_dir_1),
        .i_bomb      (i_bomb_1),
        .i_bomb_num  (i_bomb_num_1),
        .i_wall_map  (i_wall_map),
        .i_bomb_map  (i_bomb_map),
        .o_pos       (p1_pos),
        .o_face      (o_p1_face),
        .o_set_bomb  (o_p1_set_bomb)
    );

    player_unit #(.START_TILE(P2_START)) u_p2 (
        .clk         (clk),
        .rst         (rst),
        .i_cmd_valid (i_cmd_valid_2),
        .i_dir       (i_dir_2),
        .i_bomb      (i_bomb_2),
        .i_bomb_num  (i_bomb_num_2),
        .i_wall_map  (i_wall_map),
        .i_bomb_map  (i_bomb_map),
        .o_pos       (p2_pos),
        .o_face      (o_p2_face),
        .o_set_bomb  (o_p2_set_bomb)
    );

    // coordinate outputs straight from the two address views
    assign o_p1_x     = p1_pos.rc[AXIS_X];
    assign o_p1_y     = p1_pos.rc[AXIS_Y];
    assign o_p1_coord = p1_pos.flat;
    assign o_p2_x     = p2_pos.rc[AXIS_X];
    assign o_p2_y     = p2_pos.rc[AXIS_Y];
    assign o_p2_coord = p2_pos.flat;

endmodule

// ==== tb_bomber.sv ====
`timescale 1ns/100ps

module tb_bomber
    import bomber_pkg::*;
();

    localparam string STIM_FILE    = "bomber_stimulus.txt";
    localparam int    RESET_CYCLES = 16;
    localparam int    MAX_RECORDS  = 200;
    localparam int    MAX_GAP      = 32;

    logic                           clk;
    logic                           rst;
    logic                           i_cmd_valid_1;
    logic [DIR_BITS-1:0]            i_dir_1;
    logic                           i_bomb_1;
    logic [BOMB_CNT_BITS-1:0]       i_bomb_num_1;
    logic                           i_cmd_valid_2;
    logic [DIR_BITS-1:0]            i_dir_2;
    logic                           i_bomb_2;
    logic [BOMB_CNT_BITS-1:0]       i_bomb_num_2;
    logic [NUM_TILES*WALL_BITS-1:0] i_wall_map;
    logic [NUM_TILES-1:0]           i_bomb_map;
    logic [GRID_BITS-1:0]           o_p1_x;
    logic [GRID_BITS-1:0]           o_p1_y;
    logic [TILE_BITS-1:0]           o_p1_coord;
    logic [FACE_BITS-1:0]           o_p1_face;
    logic                           o_p1_set_bomb;
    logic [GRID_BITS-1:0]           o_p2_x;
    logic [GRID_BITS-1:0]           o_p2_y;
    logic [TILE_BITS-1:0]           o_p2_coord;
    logic [FACE_BITS-1:0]           o_p2_face;
    logic                           o_p2_set_bomb;

    int errors;
    int tests;
    int failed;

    // one pending command per player, index is the player number
    int pend_valid [1:2];
    int pend_dir   [1:2];
    int pend_bomb  [1:2];
    int pend_num   [1:2];
    int exp_x      [1:2];
    int exp_y      [1:2];
    int exp_face   [1:2];
    int exp_set    [1:2];

    bomber_ctrl_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .i_cmd_valid_1 (i_cmd_valid_1),
        .i_dir_1       (i_dir_1),
        .i_bomb_1      (i_bomb_1),
        .i_bomb_num_1  (i_bomb_num_1),
        .i_cmd_valid_2 (i_cmd_valid_2),
        .i_dir_2       (i_dir_2),
        .i_bomb_2      (i_bomb_2),
        .i_bomb_num_2  (i_bomb_num_2),
        .i_wall_map    (i_wall_map),
        .i_bomb_map    (i_bomb_map),
        .o_p1_x        (o_p1_x),
        .o_p1_y        (o_p1_y),
        .o_p1_coord    (o_p1_coord),
        .o_p1_face     (o_p1_face),
        .o_p1_set_bomb (o_p1_set_bomb),
        .o_p2_x        (o_p2_x),
        .o_p2_y        (o_p2_y),
        .o_p2_coord    (o_p2_coord),
        .o_p2_face     (o_p2_face),
        .o_p2_set_bomb (o_p2_set_bomb)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // coord is expected as y*16+x
    task automatic check_player(input int p, input int ex, input int ey, input int ef);
        if (p == 1) begin
            check_value("o_p1_x", 32'(o_p1_x), ex);
            check_value("o_p1_y", 32'(o_p1_y), ey);
            check_value("o_p1_coord", 32'(o_p1_coord), ey * 16 + ex);
            check_value("o_p1_face", 32'(o_p1_face), ef);
        end else begin
            check_value("o_p2_x", 32'(o_p2_x), ex);
            check_value("o_p2_y", 32'(o_p2_y), ey);
            check_value("o_p2_coord", 32'(o_p2_coord), ey * 16 + ex);
            check_value("o_p2_face", 32'(o_p2_face), ef);
        end
    endtask

    task automatic report_test(input string what, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests, what);
        end else begin
            failed++;
            $display("test %0d %s: failed", tests, what);
        end
    endtask

    // strobe all pending commands together, then watch the result window
    task automatic issue_commands(input int gap);
        int pulses [1:2];
        int late   [1:2];
        int p;
        int cyc;
        int want;
        int window;
        int err_before;
        err_before = errors;
        window = gap;
        if (gap < 2 || gap > MAX_GAP) begin
            $display("gap of %0d cycles cannot be observed, using 2", gap);
            errors++;
            window = 2;
        end
        for (p = 1; p <= 2; p++) begin
            pulses[p] = 0;
            late[p]   = 0;
        end
        @(posedge clk);
        if (pend_valid[1] != 0) begin
            i_cmd_valid_1 <= 1'b1;
            i_dir_1       <= pend_dir[1][DIR_BITS-1:0];
            i_bomb_1      <= pend_bomb[1][0];
            i_bomb_num_1  <= pend_num[1][BOMB_CNT_BITS-1:0];
        end
        if (pend_valid[2] != 0) begin
            i_cmd_valid_2 <= 1'b1;
            i_dir_2       <= pend_dir[2][DIR_BITS-1:0];
            i_bomb_2      <= pend_bomb[2][0];
            i_bomb_num_2  <= pend_num[2][BOMB_CNT_BITS-1:0];
        end
        @(posedge clk);
        i_cmd_valid_1 <= 1'b0;
        i_cmd_valid_2 <= 1'b0;
        // result lands one cycle after the sampling edge
        for (cyc = 0; cyc < window; cyc++) begin
            @(negedge clk);
            if (o_p1_set_bomb) begin
                pulses[1]++;
                if (cyc != 1) late[1]++;
            end
            if (o_p2_set_bomb) begin
                pulses[2]++;
                if (cyc != 1) late[2]++;
            end
            if (cyc == 1) begin
                for (p = 1; p <= 2; p++) begin
                    if (pend_valid[p] != 0) begin
                        check_player(p, exp_x[p], exp_y[p], exp_face[p]);
                    end
                end
            end
        end
        for (p = 1; p <= 2; p++) begin
            want = (pend_valid[p] != 0) ? exp_set[p] : 0;
            if (want != 0 && pulses[p] == 0) begin
                $display("no set-bomb pulse from player %0d within %0d cycles", p, window);
                errors++;
            end else begin
                check_value($sformatf("o_p%0d_set_bomb pulse count", p), pulses[p], want);
            end
            if (late[p] != 0) begin
                $display("set-bomb pulse from player %0d came in the wrong cycle", p);
                errors++;
            end
        end
        report_test($sformatf("command p1=%0d p2=%0d gap %0d", pend_valid[1],
                              pend_valid[2], gap), err_before);
        pend_valid[1] = 0;
        pend_valid[2] = 0;
    endtask

    initial begin
        logic [8*8-1:0]   tok;
        logic [8*128-1:0] line;
        int fd;
        int rc;
        int n;
        int records;
        int err_before;
        int p;
        int dir;
        int bomb;
        int num;
        int gap;
        int ex;
        int ey;
        int ef;
        int es;
        int tile;
        int code;
        errors = 0;
        tests = 0;
        failed = 0;
        clk = 1'b0;
        rst = 1'b1;
        i_cmd_valid_1 = 1'b0;
        i_dir_1 = '0;
        i_bomb_1 = 1'b0;
        i_bomb_num_1 = '0;
        i_cmd_valid_2 = 1'b0;
        i_dir_2 = '0;
        i_bomb_2 = 1'b0;
        i_bomb_num_2 = '0;
        i_wall_map = '0;
        i_bomb_map = '0;
        pend_valid[1] = 0;
        pend_valid[2] = 0;

        for (n = 0; n < RESET_CYCLES; n++) begin
            @(posedge clk);
        end
        rst <= 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", STIM_FILE);
            errors++;
        end else begin
            records = 0;
            while (!$feof(fd)) begin
                rc = $fscanf(fd, "%s", tok);
                if (rc != 1) break;
                records++;
                if (records > MAX_RECORDS) begin
                    $display("stimulus file has more than %0d records, run stopped",
                             MAX_RECORDS);
                    errors++;
                    break;
                end
                if (tok == "#") begin
                    rc = $fgets(line, fd);
                end else if (tok == "w") begin
                    rc = $fscanf(fd, "%d %d", tile, code);
                    @(posedge clk);
                    i_wall_map[tile[TILE_BITS-1:0]*WALL_BITS +: WALL_BITS] <= code[1:0];
                end else if (tok == "b") begin
                    rc = $fscanf(fd, "%d", tile);
                    @(posedge clk);
                    i_bomb_map[tile[TILE_BITS-1:0]] <= 1'b1;
                end else if (tok == "k") begin
                    rc = $fscanf(fd, "%d %d %d %d", p, ex, ey, ef);
                    @(negedge clk);
                    err_before = errors;
                    check_player(p, ex, ey, ef);
                    if (p == 1) begin
                        check_value("o_p1_set_bomb", 32'(o_p1_set_bomb), 0);
                    end else begin
                        check_value("o_p2_set_bomb", 32'(o_p2_set_bomb), 0);
                    end
                    report_test($sformatf("state of player %0d", p), err_before);
                end else if (tok == "m") begin
                    rc = $fscanf(fd, "%d %d %d %d %d %d %d %d %d",
                                 p, dir, bomb, num, gap, ex, ey, ef, es);
                    pend_valid[p] = 1;
                    pend_dir[p]   = dir;
                    pend_bomb[p]  = bomb;
                    pend_num[p]   = num;
                    exp_x[p]      = ex;
                    exp_y[p]      = ey;
                    exp_face[p]   = ef;
                    exp_set[p]    = es;
                    // gap 0 pairs this command with the next record
                    if (gap != 0) begin
                        issue_commands(gap);
                    end
                end else begin
                    $display("unknown record type in stimulus file, run stopped");
                    errors++;
                    break;
                end
            end
            $fclose(fd);
            if (pend_valid[1] != 0 || pend_valid[2] != 0) begin
                $display("paired command at the end of the stimulus was never issued");
                errors++;
            end
        end

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && tests > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== bomber_stimulus.txt ====
# w tile code | b tile | k player x y face
# m player dir bomb bomb_num gap exp_x exp_y exp_face exp_set_bomb, gap 0 pairs with next
w 18 1
w 3 2
w 48 3
w 1 0
b 33
b 223
k 1 0 0 0
k 2 15 15 0
# player 1 edges, walls, bomb tile and stop codes
m 1 0 0 0 3 0 0 0 0
m 1 2 0 0 3 0 0 2 0
m 1 3 0 0 3 1 0 3 0
m 1 3 0 0 3 2 0 3 0
m 1 3 0 0 3 2 0 3 0
m 1 1 0 0 3 2 0 1 0
m 1 2 0 0 3 1 0 2 0
m 1 1 0 0 3 1 1 1 0
m 1 1 0 0 3 1 1 1 0
m 1 4 0 0 3 1 1 1 0
m 1 7 0 0 3 1 1 1 0
m 1 2 0 0 3 0 1 2 0
m 1 1 0 0 3 0 2 1 0
m 1 1 0 0 3 0 2 1 0
m 1 0 0 0 3 0 1 0 0
# bomb limit and cooldown window
m 1 4 1 4 3 0 1 0 1
m 1 3 1 5 3 1 1 3 0
m 1 0 0 0 2 1 0 0 0
m 1 4 1 0 3 1 0 0 0
m 1 4 1 0 3 1 0 0 1
# both players, separate cooldowns
m 1 3 1 2 0 2 0 3 1
m 2 0 1 1 3 15 14 0 1
m 2 2 1 0 2 14 14 2 1
m 1 4 1 0 3 2 0 3 1
m 1 0 1 0 0 2 0 0 1
m 2 0 1 0 2 14 13 0 1
m 2 1 1 0 3 14 14 1 0
m 1 4 1 0 3 2 0 0 1
m 2 1 1 0 3 14 15 1 1
m 2 3 1 5 3 15 15 3 0
k 1 2 0 0
k 2 15 15 3

// ==== tb.f ====
bomber_pkg.sv
player_fsm.sv
bomb_cooldown.sv
tile_probe.sv
player_unit.sv
bomber_ctrl_top.sv
tb_bomber.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_bomber
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_bomber)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Regression passed$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
